/* include/zports_defs.svh */
// zports definitions: I/O port addresses, #nnAF register indices and reset values
`ifndef ZPORTS_DEFS_SVH
`define ZPORTS_DEFS_SVH

// low address byte of each decoded port
`define ZP_PORT_FE      8'hFE
`define ZP_PORT_FD      8'hFD   // #7FFD paging, a[15] low
`define ZP_PORT_XT      8'hAF   // extended register file
`define ZP_PORT_COVOX   8'hFB
`define ZP_PORT_KJOY    8'h1F   // kempston joystick, outside dos only
`define ZP_PORT_KMOUSE  8'hDF
`define ZP_PORT_SDCFG   8'h77
`define ZP_PORT_SDDAT   8'h57

// #nnAF register indices, written side
`define ZP_XT_XBORDER   8'h0F
`define ZP_XT_RAMPAGE   8'h10   // four pages, #10 to #13
`define ZP_XT_FMADDR    8'h15
`define ZP_XT_SYSCONF   8'h20
`define ZP_XT_MEMCONF   8'h21
`define ZP_XT_INTMASK   8'h2A
`define ZP_XT_CACHECONF 8'h2B

// #nnAF register indices, read side
`define ZP_XT_XSTAT     8'h00
`define ZP_XT_DMASTAT   8'h27

// reset values
`define ZP_RST_MEMCONF  8'h04   // rom, no map
`define ZP_RST_PAGE0    8'h00
`define ZP_RST_PAGE1    8'h05
`define ZP_RST_PAGE2    8'h02
`define ZP_RST_PAGE3    8'h00
`define ZP_RST_INTMASK  8'h01   // frame interrupt only

`endif

/* src/zports_pkg.sv */
// zports shared types: data bytes, RAM page numbers and the #7FFD lock modes
`default_nettype none

package zports_pkg;

  typedef logic [7:0] byte_t;   // data or address byte
  typedef logic [7:0] page_t;   // RAM page number

  // memconf[7:6]
  typedef enum logic [1:0]
  {
    LOCK_NONE = 2'b00,  // #7FFD bits 7:6 select pages
    LOCK_48   = 2'b01,  // bits 7:6 forced to zero
    LOCK_M1   = 2'b10,  // lock decided by the last opcode
    LOCK_512  = 2'b11   // 3-bit extension, no 48K lock
  } lock_mode_t;

endpackage

`default_nettype wire

/* src/port_decode.sv */
// port decoder that matches I/O addresses and turns the bus strobes into port strobes
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module port_decode
(
  input  wire [15:0]             a,
  input  wire                    iowr_s,
  input  wire                    iord_s,
  input  wire                    regs_we,   // loader write with the index on a[7:0]
  input  wire                    dos,
  input  wire                    lock48,
  output zports_pkg::byte_t      xt_index,
  output logic                   xt_wr,
  output logic                   xt_stat_rd,
  output logic                   p7ffd_wr,
  output logic                   fe_wr,
  output logic                   covox_wr,
  output logic                   sdcfg_wr,
  output logic                   sddat_wr,
  output logic                   sddat_rd,
  output logic                   porthit
);

  zports_pkg::byte_t loa;
  logic hit_fe, hit_fd, hit_xt, hit_covox;
  logic hit_kjoy, hit_kmouse, hit_sdcfg, hit_sddat;

  assign loa = a[7:0];

  assign hit_fe     = (loa == `ZP_PORT_FE);
  assign hit_fd     = (loa == `ZP_PORT_FD);
  assign hit_xt     = (loa == `ZP_PORT_XT);
  assign hit_covox  = (loa == `ZP_PORT_COVOX);
  assign hit_kjoy   = (loa == `ZP_PORT_KJOY);
  assign hit_kmouse = (loa == `ZP_PORT_KMOUSE);
  assign hit_sdcfg  = (loa == `ZP_PORT_SDCFG);
  assign hit_sddat  = (loa == `ZP_PORT_SDDAT);

  assign xt_index = regs_we ? a[7:0] : a[15:8];

  assign xt_wr      = (hit_xt && iowr_s) || regs_we;
  assign xt_stat_rd = hit_xt && iord_s && (xt_index == `ZP_XT_XSTAT);
  assign p7ffd_wr   = hit_fd && !a[15] && iowr_s && !lock48; // a[15] high is AY
  assign sddat_rd   = hit_sddat && iord_s;

  // single-port write strobes
  always_comb
  begin
    fe_wr    = hit_fe && iowr_s;
    covox_wr = hit_covox && iowr_s;
    sdcfg_wr = hit_sdcfg && iowr_s && !dos;
    sddat_wr = hit_sddat && iowr_s && !dos;
    // one bus cycle never reads and writes at once
    assert (!(iowr_s && iord_s))
      else $error("port_decode: I/O read and write strobes together");
  end

  assign porthit = hit_fe || hit_xt || hit_fd || hit_covox
                || (hit_kjoy && !dos)
                || hit_kmouse
                || ((hit_sdcfg || hit_sddat) && !dos);

endmodule

`default_nettype wire

/* src/mem_paging.sv */
// memory paging block with the RAM page registers, memconf and #7FFD writes under 48K/128K locks
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module mem_paging
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire zports_pkg::byte_t din,
  input  wire                    opfetch,
  input  wire                    xt_wr,
  input  wire                    p7ffd_wr,
  input  wire zports_pkg::byte_t xt_index,
  output zports_pkg::byte_t      memconf,
  output logic [31:0]            xt_page,
  output zports_pkg::page_t      page2,
  output zports_pkg::page_t      page3,
  output logic                   lock48
);

  zports_pkg::page_t      pages [0:3];
  zports_pkg::lock_mode_t lock_mode;
  logic                   m1_lock;    // set when the last opcode locks 128K paging
  logic [2:0]             ext;        // page 3 bits 5:3 from #7FFD
  logic                   page_hit;

  assign lock_mode = zports_pkg::lock_mode_t'(memconf[7:6]);
  assign page_hit  = (xt_index[7:2] == `ZP_XT_RAMPAGE >> 2);

  always_comb
  begin
    case (lock_mode)
      zports_pkg::LOCK_NONE: ext = {1'b0, din[7:6]};
      zports_pkg::LOCK_48:   ext = 3'b000;
      zports_pkg::LOCK_M1:   ext = m1_lock ? 3'b000 : {1'b0, din[7:6]};
      default:               ext = {din[5], din[7:6]};  // 512K
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock <= 1'b0;
    else if (opfetch)
      m1_lock <= ~(din[7] ^ din[6]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      memconf  <= `ZP_RST_MEMCONF;
      pages[0] <= `ZP_RST_PAGE0;
      pages[1] <= `ZP_RST_PAGE1;
      pages[2] <= `ZP_RST_PAGE2;
      pages[3] <= `ZP_RST_PAGE3;
    end
    else
    begin
      if (xt_wr && page_hit)
        pages[xt_index[1:0]] <= din;
      if (xt_wr && (xt_index == `ZP_XT_MEMCONF))
        memconf <= din;

      // #7FFD comes last and wins over a same-cycle #nnAF write
      if (p7ffd_wr)
      begin
        memconf[0] <= din[4];                   // rom select
        pages[3]   <= {2'b00, ext, din[2:0]};
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != zports_pkg::LOCK_512))
      lock48 <= din[5];
  end

  assign xt_page = {pages[3], pages[2], pages[1], pages[0]};
  assign page2   = pages[2];
  assign page3   = pages[3];

  // no #7FFD write gets through once the 48K lock is set
  assert property (@(posedge clk) disable iff (rst) lock48 |-> !p7ffd_wr)
    else $error("mem_paging: #7FFD write while the 48K lock is set");

endmodule

`default_nettype wire

/* src/ctrl_regs.sv */
// control registers: sysconf, cacheconf, intmask, fmaddr and the SD card port pair
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module ctrl_regs
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire zports_pkg::byte_t din,
  input  wire                    xt_wr,
  input  wire zports_pkg::byte_t xt_index,
  input  wire                    sdcfg_wr,
  input  wire                    sddat_wr,
  input  wire                    sddat_rd,
  output zports_pkg::byte_t      sysconf,
  output zports_pkg::byte_t      intmask,
  output logic [3:0]             cacheconf,
  output logic [4:0]             fmaddr,
  output logic                   sdcs_n,
  output logic                   sd_start,
  output zports_pkg::byte_t      sd_datain
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sysconf   <= 8'h00;         // 3.5 MHz
      cacheconf <= 4'h0;          // no cache
      intmask   <= `ZP_RST_INTMASK;
      fmaddr[4] <= 1'b0;          // FM window off
    end
    else if (xt_wr)
    begin
      if (xt_index == `ZP_XT_FMADDR)
        fmaddr <= din[4:0];

      if (xt_index == `ZP_XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {4{din[2]}};  // cache follows turbo bit
      end

      if (xt_index == `ZP_XT_CACHECONF)
        cacheconf <= din[3:0];

      if (xt_index == `ZP_XT_INTMASK)
        intmask <= din;
    end
  end

  // #77 write drives the card select
  always_ff @(posedge clk)
  begin
    if (rst)
      sdcs_n <= 1'b1;
    else if (sdcfg_wr)
      sdcs_n <= din[1];
  end

  // any #57 access starts one SPI byte exchange
  assign sd_start  = sddat_wr || sddat_rd;
  assign sd_datain = sddat_wr ? din : 8'hFF;   // reads clock out ones

  // decoder must keep its strobes quiet during reset
  assert property (@(posedge clk) rst |-> !sd_start)
    else $error("ctrl_regs: SD transfer started during reset");

endmodule

`default_nettype wire

/* src/port_readback.sv */
// port read-back: I/O read data multiplexer and the power-up status bit
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module port_readback
(
  input  wire                    clk,
  input  wire zports_pkg::byte_t loa,
  input  wire zports_pkg::byte_t xt_index,
  input  wire                    xt_stat_rd,
  input  wire [4:0]              keys_in,
  input  wire                    tape_read,
  input  wire [4:0]              kj_in,
  input  wire zports_pkg::byte_t mus_in,
  input  wire zports_pkg::byte_t sd_dataout,
  input  wire                    dma_act,
  input  wire zports_pkg::page_t page2,
  input  wire zports_pkg::page_t page3,
  input  wire                    iord,
  input  wire                    porthit,
  output zports_pkg::byte_t      dout,
  output logic                   dataout
);

  // set at configuration, cleared by the first status read
  logic pwr_up = 1'b1;
  zports_pkg::byte_t xt_dout;

  always_ff @(posedge clk)
  begin
    if (xt_stat_rd)
      pwr_up <= 1'b0;
  end

  // #nnAF read side
  always_comb
  begin
    case (xt_index)
      `ZP_XT_XSTAT:             xt_dout = {1'b0, pwr_up, 6'b000000};
      `ZP_XT_DMASTAT:           xt_dout = {dma_act, 7'b0000000};
      `ZP_XT_RAMPAGE + 8'd2:    xt_dout = page2;
      `ZP_XT_RAMPAGE + 8'd3:    xt_dout = page3;
      default:                  xt_dout = 8'hFF;
    endcase
  end

  always_comb
  begin
    case (loa)
      `ZP_PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
      `ZP_PORT_KJOY:   dout = {3'b000, kj_in};
      `ZP_PORT_KMOUSE: dout = mus_in;
      `ZP_PORT_SDCFG:  dout = 8'h00;        // card present, not protected
      `ZP_PORT_SDDAT:  dout = sd_dataout;
      `ZP_PORT_XT:     dout = xt_dout;
      default:         dout = 8'hFF;
    endcase
  end

  assign dataout = porthit && iord;   // drive the bus only for own ports

endmodule

`default_nettype wire

/* src/zports_top.sv */
// zports top: I/O port block with decoder, paging, control registers and read-back
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module zports_top
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire [15:0]             a,
  input  wire zports_pkg::byte_t din,
  input  wire                    iowr_s,
  input  wire                    iord_s,
  input  wire                    iord,
  input  wire                    regs_we,
  input  wire                    opfetch,
  input  wire                    dos,
  input  wire [4:0]              keys_in,
  input  wire                    tape_read,
  input  wire [4:0]              kj_in,
  input  wire zports_pkg::byte_t mus_in,
  input  wire zports_pkg::byte_t sd_dataout,
  input  wire                    dma_act,
  output wire zports_pkg::byte_t dout,
  output wire                    dataout,
  output wire                    porthit,
  output wire                    zborder_wr,
  output wire                    beeper_wr,
  output wire                    border_wr,
  output wire                    covox_wr,
  output wire [31:0]             xt_page,
  output wire zports_pkg::byte_t memconf,
  output wire zports_pkg::byte_t sysconf,
  output wire [3:0]              cacheconf,
  output wire zports_pkg::byte_t intmask,
  output wire [4:0]              fmaddr,
  output wire                    sdcs_n,
  output wire                    sd_start,
  output wire zports_pkg::byte_t sd_datain
);

  zports_pkg::byte_t xt_index;
  zports_pkg::page_t page2, page3;
  logic xt_wr, xt_stat_rd, p7ffd_wr, fe_wr;
  logic sdcfg_wr, sddat_wr, sddat_rd, lock48;

  port_decode port_decode_i
  (
    .a          (a),
    .iowr_s     (iowr_s),
    .iord_s     (iord_s),
    .regs_we    (regs_we),
    .dos        (dos),
    .lock48     (lock48),
    .xt_index   (xt_index),
    .xt_wr      (xt_wr),
    .xt_stat_rd (xt_stat_rd),
    .p7ffd_wr   (p7ffd_wr),
    .fe_wr      (fe_wr),
    .covox_wr   (covox_wr),
    .sdcfg_wr   (sdcfg_wr),
    .sddat_wr   (sddat_wr),
    .sddat_rd   (sddat_rd),
    .porthit    (porthit)
  );

  mem_paging mem_paging_i
  (
    .clk      (clk),
    .rst      (rst),
    .din      (din),
    .opfetch  (opfetch),
    .xt_wr    (xt_wr),
    .p7ffd_wr (p7ffd_wr),
    .xt_index (xt_index),
    .memconf  (memconf),
    .xt_page  (xt_page),
    .page2    (page2),
    .page3    (page3),
    .lock48   (lock48)
  );

  ctrl_regs ctrl_regs_i
  (
    .clk       (clk),
    .rst       (rst),
    .din       (din),
    .xt_wr     (xt_wr),
    .xt_index  (xt_index),
    .sdcfg_wr  (sdcfg_wr),
    .sddat_wr  (sddat_wr),
    .sddat_rd  (sddat_rd),
    .sysconf   (sysconf),
    .intmask   (intmask),
    .cacheconf (cacheconf),
    .fmaddr    (fmaddr),
    .sdcs_n    (sdcs_n),
    .sd_start  (sd_start),
    .sd_datain (sd_datain)
  );

  port_readback port_readback_i
  (
    .clk        (clk),
    .loa        (a[7:0]),
    .xt_index   (xt_index),
    .xt_stat_rd (xt_stat_rd),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .sd_dataout (sd_dataout),
    .dma_act    (dma_act),
    .page2      (page2),
    .page3      (page3),
    .iord       (iord),
    .porthit    (porthit),
    .dout       (dout),
    .dataout    (dataout)
  );

  // #FE feeds both the ZX border and the beeper
  assign zborder_wr = fe_wr;
  assign beeper_wr  = fe_wr;
  assign border_wr  = xt_wr && (xt_index == `ZP_XT_XBORDER);

endmodule

`default_nettype wire

/* dv/tb_zports.sv */
// zports testbench: drives the I/O port block and checks it against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "zports_defs.svh"

module tb_zports;

  localparam int N_XT = 150;
  localparam int N_P7 = 40;
  localparam int N_RD = 150;
  localparam int N_SD = 60;
  // every bus op takes two cycles, each lock mode adds a reset and a memconf write
  localparam int TOTAL_CYCLES = 8 + 4 + 2 * N_XT + 4 * (12 + 2 * N_P7) + 2 * N_RD + 2 * N_SD;
  localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES;

  logic        clk;
  logic        rst;
  logic [15:0] a;
  logic [7:0]  din;
  logic        iowr_s;
  logic        iord_s;
  logic        iord;
  logic        regs_we;
  logic        opfetch;
  logic        dos;
  logic [4:0]  keys_in;
  logic        tape_read;
  logic [4:0]  kj_in;
  logic [7:0]  mus_in;
  logic [7:0]  sd_dataout;
  logic        dma_act;
  wire  [7:0]  dout;
  wire         dataout;
  wire         porthit;
  wire         zborder_wr;
  wire         beeper_wr;
  wire         border_wr;
  wire         covox_wr;
  wire  [31:0] xt_page;
  wire  [7:0]  memconf;
  wire  [7:0]  sysconf;
  wire  [3:0]  cacheconf;
  wire  [7:0]  intmask;
  wire  [4:0]  fmaddr;
  wire         sdcs_n;
  wire         sd_start;
  wire  [7:0]  sd_datain;

  // model state
  logic [7:0] m_pages [0:3];
  logic [7:0] m_memconf;
  logic [7:0] m_sysconf;
  logic [7:0] m_intmask;
  logic [3:0] m_cacheconf;
  logic [4:0] m_fmaddr;
  logic       fm_known;      // low fmaddr bits have no reset value
  logic       m_sdcs_n;
  logic       m_lock48;
  logic       m_m1;
  logic       m_pwr_up = 1'b1;
  logic       model_ready = 1'b0;
  int         fail_count = 0;
  int         cycle_count = 0;

  zports_top zports_top_i
  (
    .clk        (clk),
    .rst        (rst),
    .a          (a),
    .din        (din),
    .iowr_s     (iowr_s),
    .iord_s     (iord_s),
    .iord       (iord),
    .regs_we    (regs_we),
    .opfetch    (opfetch),
    .dos        (dos),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .sd_dataout (sd_dataout),
    .dma_act    (dma_act),
    .dout       (dout),
    .dataout    (dataout),
    .porthit    (porthit),
    .zborder_wr (zborder_wr),
    .beeper_wr  (beeper_wr),
    .border_wr  (border_wr),
    .covox_wr   (covox_wr),
    .xt_page    (xt_page),
    .memconf    (memconf),
    .sysconf    (sysconf),
    .cacheconf  (cacheconf),
    .intmask    (intmask),
    .fmaddr     (fmaddr),
    .sdcs_n     (sdcs_n),
    .sd_start   (sd_start),
    .sd_datain  (sd_datain)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      fail_count++;
      $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
      $display(">>> FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // page 3 after a #7FFD write, by lock mode
  function automatic logic [7:0] ref_page3(input zports_pkg::lock_mode_t mode,
                                           input logic m1, input logic [7:0] d);
    case (mode)
      zports_pkg::LOCK_NONE: ref_page3 = {3'b000, d[7:6], d[2:0]};
      zports_pkg::LOCK_48:   ref_page3 = {5'b00000, d[2:0]};
      zports_pkg::LOCK_M1:   ref_page3 = m1 ? {5'b00000, d[2:0]} : {3'b000, d[7:6], d[2:0]};
      default:               ref_page3 = {2'b00, d[5], d[7:6], d[2:0]};
    endcase
  endfunction

  function automatic logic ref_porthit(input logic [15:0] addr, input logic dos_v);
    logic [7:0] lo;
    lo = addr[7:0];
    ref_porthit = (lo == `ZP_PORT_FE) || (lo == `ZP_PORT_XT) || (lo == `ZP_PORT_FD)
               || (lo == `ZP_PORT_COVOX) || (lo == `ZP_PORT_KMOUSE)
               || (!dos_v && ((lo == `ZP_PORT_KJOY) || (lo == `ZP_PORT_SDCFG)
                              || (lo == `ZP_PORT_SDDAT)));
  endfunction

  function automatic logic [7:0] ref_dout(input logic [15:0] addr, input logic regs);
    logic [7:0] idx;
    logic [7:0] xt;
    idx = regs ? addr[7:0] : addr[15:8];
    if (idx == `ZP_XT_XSTAT)
      xt = {1'b0, m_pwr_up, 6'b000000};
    else if (idx == `ZP_XT_DMASTAT)
      xt = {dma_act, 7'b0000000};
    else if (idx == `ZP_XT_RAMPAGE + 8'd2)
      xt = m_pages[2];
    else if (idx == `ZP_XT_RAMPAGE + 8'd3)
      xt = m_pages[3];
    else
      xt = 8'hFF;
    case (addr[7:0])
      `ZP_PORT_FE:     ref_dout = {1'b1, tape_read, 1'b0, keys_in};
      `ZP_PORT_KJOY:   ref_dout = {3'b000, kj_in};
      `ZP_PORT_KMOUSE: ref_dout = mus_in;
      `ZP_PORT_SDCFG:  ref_dout = 8'h00;
      `ZP_PORT_SDDAT:  ref_dout = sd_dataout;
      `ZP_PORT_XT:     ref_dout = xt;
      default:         ref_dout = 8'hFF;
    endcase
  endfunction

  // model registers, sampled on the same edge as the DUT
  always @(posedge clk)
  begin : model_update
    logic [7:0] idx;
    logic xtw, p7w;
    zports_pkg::lock_mode_t mode;
    idx  = regs_we ? a[7:0] : a[15:8];
    xtw  = ((a[7:0] == `ZP_PORT_XT) && iowr_s) || regs_we;
    p7w  = (a[7:0] == `ZP_PORT_FD) && !a[15] && iowr_s && !m_lock48;
    mode = zports_pkg::lock_mode_t'(m_memconf[7:6]);
    if ((a[7:0] == `ZP_PORT_XT) && iord_s && (idx == `ZP_XT_XSTAT))
      m_pwr_up = 1'b0;   // power-up bit ignores rst
    if (rst)
    begin
      m_pages[0]  = `ZP_RST_PAGE0;
      m_pages[1]  = `ZP_RST_PAGE1;
      m_pages[2]  = `ZP_RST_PAGE2;
      m_pages[3]  = `ZP_RST_PAGE3;
      m_memconf   = `ZP_RST_MEMCONF;
      m_sysconf   = 8'h00;
      m_cacheconf = 4'h0;
      m_intmask   = `ZP_RST_INTMASK;
      m_fmaddr[4] = 1'b0;
      m_sdcs_n    = 1'b1;
      m_lock48    = 1'b0;
      m_m1        = 1'b0;
      model_ready = 1'b1;
    end
    else
    begin
      if (xtw)
      begin
        if ((idx & 8'hFC) == `ZP_XT_RAMPAGE)
          m_pages[idx[1:0]] = din;
        case (idx)
          `ZP_XT_MEMCONF:   m_memconf = din;
          `ZP_XT_INTMASK:   m_intmask = din;
          `ZP_XT_CACHECONF: m_cacheconf = din[3:0];
          `ZP_XT_SYSCONF:
          begin
            m_sysconf   = din;
            m_cacheconf = {4{din[2]}};
          end
          `ZP_XT_FMADDR:
          begin
            m_fmaddr = din[4:0];
            fm_known = 1'b1;
          end
          default: ;
        endcase
      end
      if (p7w)
      begin
        m_pages[3]   = ref_page3(mode, m_m1, din);   // old m1 flag
        m_memconf[0] = din[4];
        if (mode != zports_pkg::LOCK_512)
          m_lock48 = din[5];
      end
      if (opfetch)
        m_m1 = ~(din[7] ^ din[6]);
      if ((a[7:0] == `ZP_PORT_SDCFG) && iowr_s && !dos)
        m_sdcs_n = din[1];
    end
  end

  // compare mid-cycle, away from the edges
  always @(negedge clk)
  begin : compare
    logic [7:0] idx;
    logic xtw, fe_w, sd_wr, sd_rd;
    idx   = regs_we ? a[7:0] : a[15:8];
    xtw   = ((a[7:0] == `ZP_PORT_XT) && iowr_s) || regs_we;
    fe_w  = (a[7:0] == `ZP_PORT_FE) && iowr_s;
    sd_wr = (a[7:0] == `ZP_PORT_SDDAT) && iowr_s && !dos;
    sd_rd = (a[7:0] == `ZP_PORT_SDDAT) && iord_s;
    if (model_ready)
    begin
      check_value("xt_page", xt_page, {m_pages[3], m_pages[2], m_pages[1], m_pages[0]});
      check_value("memconf", 32'(memconf), 32'(m_memconf));
      check_value("sysconf", 32'(sysconf), 32'(m_sysconf));
      check_value("cacheconf", 32'(cacheconf), 32'(m_cacheconf));
      check_value("intmask", 32'(intmask), 32'(m_intmask));
      check_value("fmaddr", fm_known ? 32'(fmaddr) : 32'(fmaddr[4]),
                  fm_known ? 32'(m_fmaddr) : 32'(m_fmaddr[4]));
      check_value("sdcs_n", 32'(sdcs_n), 32'(m_sdcs_n));
      check_value("dout", 32'(dout), 32'(ref_dout(a, regs_we)));
      check_value("porthit", 32'(porthit), 32'(ref_porthit(a, dos)));
      check_value("dataout", 32'(dataout), 32'(ref_porthit(a, dos) && iord));
      check_value("zborder_wr", 32'(zborder_wr), 32'(fe_w));
      check_value("beeper_wr", 32'(beeper_wr), 32'(fe_w));
      check_value("border_wr", 32'(border_wr), 32'(xtw && (idx == `ZP_XT_XBORDER)));
      check_value("covox_wr", 32'(covox_wr), 32'((a[7:0] == `ZP_PORT_COVOX) && iowr_s));
      check_value("sd_start", 32'(sd_start), 32'(sd_wr || sd_rd));
      check_value("sd_datain", 32'(sd_datain), sd_wr ? 32'(din) : 32'h0000_00FF);
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT)
    begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  // one bus op: strobes for one cycle, then one quiet cycle
  task automatic drive_bus(input logic [15:0] addr, input logic [7:0] data, input logic wr,
                           input logic rd, input logic regs, input logic dos_v,
                           input logic opf);
    @(posedge clk);
    a          <= addr;
    din        <= data;
    iowr_s     <= wr;
    iord_s     <= rd;
    iord       <= rd;
    regs_we    <= regs;
    dos        <= dos_v;
    opfetch    <= opf;
    keys_in    <= 5'($urandom);
    tape_read  <= 1'($urandom);
    kj_in      <= 5'($urandom);
    mus_in     <= 8'($urandom);
    sd_dataout <= 8'($urandom);
    dma_act    <= 1'($urandom);
    @(posedge clk);
    iowr_s  <= 1'b0;
    iord_s  <= 1'b0;
    iord    <= 1'b0;
    regs_we <= 1'b0;
    opfetch <= 1'b0;
  endtask

  task automatic xt_write(input logic [7:0] idx, input logic [7:0] data, input logic via_regs);
    if (via_regs)
      drive_bus({8'($urandom), idx}, data, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    else
      drive_bus({idx, `ZP_PORT_XT}, data, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  initial
  begin : stimulus
    logic [7:0] xt_idx [0:9];
    logic [7:0] rd_port [0:5];
    logic [7:0] rd_idx [0:3];
    logic [7:0] d;
    logic [15:0] addr;
    int sel;
    void'($urandom(32'hd19438e8));
    xt_idx  = '{`ZP_XT_RAMPAGE, `ZP_XT_RAMPAGE + 8'd1, `ZP_XT_RAMPAGE + 8'd2,
                `ZP_XT_RAMPAGE + 8'd3, `ZP_XT_FMADDR, `ZP_XT_SYSCONF, `ZP_XT_MEMCONF,
                `ZP_XT_INTMASK, `ZP_XT_CACHECONF, `ZP_XT_XBORDER};
    rd_port = '{`ZP_PORT_FE, `ZP_PORT_KJOY, `ZP_PORT_KMOUSE, `ZP_PORT_SDCFG,
                `ZP_PORT_SDDAT, `ZP_PORT_XT};
    rd_idx  = '{`ZP_XT_XSTAT, `ZP_XT_DMASTAT, `ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3};
    fm_known   = 1'b0;
    rst        = 1'b1;
    a          = 16'h0000;
    din        = 8'h00;
    iowr_s     = 1'b0;
    iord_s     = 1'b0;
    iord       = 1'b0;
    regs_we    = 1'b0;
    opfetch    = 1'b0;
    dos        = 1'b0;
    keys_in    = 5'h1F;
    tape_read  = 1'b0;
    kj_in      = 5'h00;
    mus_in     = 8'hFF;
    sd_dataout = 8'hFF;
    dma_act    = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // status bit, first read only sees the power-up flag
    repeat (2) drive_bus({`ZP_XT_XSTAT, `ZP_PORT_XT}, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);

    repeat (N_XT)
    begin
      sel = $urandom_range(12);
      d   = 8'($urandom);
      if (sel < 10)
        xt_write(xt_idx[sel], d, 1'($urandom));
      else if (sel == 10)
        xt_write(8'($urandom), d, 1'($urandom));   // mostly unused indices
      else if (sel == 11)
        drive_bus({8'($urandom), `ZP_PORT_FE}, d, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      else
        drive_bus({8'($urandom), `ZP_PORT_COVOX}, d, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end

    // #7FFD paging, fresh lock48 for every lock mode
    for (int lm = 0; lm < 4; lm++)
    begin
      apply_reset();
      xt_write(`ZP_XT_MEMCONF, {2'(lm), 6'(`ZP_RST_MEMCONF)}, 1'b0);
      repeat (N_P7)
      begin
        d    = 8'($urandom);
        d[5] = ($urandom_range(7) == 0);   // lock only now and then
        sel  = $urandom_range(3);
        if (sel == 0)
          drive_bus(16'h0000, d, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        else
          drive_bus({(sel == 1), 7'($urandom), `ZP_PORT_FD}, d, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      end
    end

    repeat (N_RD)
    begin
      sel  = $urandom_range(3);
      addr = {rd_idx[sel], 8'($urandom)};
      if ($urandom_range(4) == 0)
        addr[15:8] = 8'($urandom);
      sel = $urandom_range(6);
      if (sel < 6)
        addr[7:0] = rd_port[sel];
      drive_bus(addr, 8'($urandom), 1'b0, 1'b1, 1'b0, 1'($urandom), 1'b0);
    end

    repeat (N_SD)
    begin
      sel = $urandom_range(2);
      d   = 8'($urandom);
      if (sel == 0)
        drive_bus({8'($urandom), `ZP_PORT_SDCFG}, d, 1'b1, 1'b0, 1'b0, 1'($urandom), 1'b0);
      else if (sel == 1)
        drive_bus({8'($urandom), `ZP_PORT_SDDAT}, d, 1'b1, 1'b0, 1'b0, 1'($urandom), 1'b0);
      else
        drive_bus({8'($urandom), `ZP_PORT_SDDAT}, d, 1'b0, 1'b1, 1'b0, 1'($urandom), 1'b0);
    end

    @(posedge clk);
    if (fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
src/zports_pkg.sv
src/port_decode.sv
src/mem_paging.sv
src/ctrl_regs.sv
src/port_readback.sv
src/zports_top.sv
dv/tb_zports.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zports
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv dv/*.sv include/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -q -F '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
